/* persp_config.svh */
`ifndef PERSP_CONFIG_SVH
`define PERSP_CONFIG_SVH

// signed Q20.13 fixed point
`define PERSP_INT_W 20
`define PERSP_FRAC_W 13

// pixel coordinate width, 0..1023
`define PERSP_COORD_W 10

// target square runs 0..99 on both axes
`define PERSP_TGT_MAX 99

// elimination schedule length, last step loads the result
`define PERSP_STEPS 8

// 1.0 in Q20.13
`define PERSP_FIX_ONE 8192

`endif

/* persp_pkg.sv */
`default_nettype none

`include "persp_config.svh"

package persp_pkg;

    localparam int fix_w = `PERSP_INT_W + `PERSP_FRAC_W;

    typedef logic signed [fix_w-1:0] fix_t;
    typedef logic [`PERSP_COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;  // upper bits
        coord_t y;
    } corner_t;

    typedef struct packed {
        corner_t ul;
        corner_t ur;
        corner_t dr;
        corner_t dl;
    } quad_t;

    typedef struct packed {
        fix_t a;
        fix_t b;
        fix_t c;
        fix_t d;
        fix_t e;
        fix_t f;
        fix_t g;
        fix_t h;
    } coef_t;

    // live cells of the 8x9 augmented matrix only
    localparam int mat_n = 32;
    typedef fix_t elim_mat_t [mat_n];

    typedef logic [$clog2(`PERSP_STEPS)-1:0] step_t;

    localparam fix_t fix_one = fix_t'(`PERSP_FIX_ONE);
    localparam fix_t fix_max = {1'b0, {(fix_w-1){1'b1}}};
    localparam fix_t fix_min = {1'b1, {(fix_w-1){1'b0}}};

    // clamp value for an overflowed result of the given sign
    function automatic fix_t sat_limit(input logic neg);
        return neg ? fix_min : fix_max;
    endfunction

    // cell indices, mRC = row R, column C
    localparam int m00 = 0;
    localparam int m01 = 1;
    localparam int m10 = 2;
    localparam int m11 = 3;
    localparam int m20 = 4;
    localparam int m21 = 5;
    localparam int m30 = 6;
    localparam int m31 = 7;
    localparam int m26 = 8;
    localparam int m27 = 9;
    localparam int m36 = 10;
    localparam int m37 = 11;
    localparam int m43 = 12;
    localparam int m44 = 13;
    localparam int m53 = 14;
    localparam int m54 = 15;
    localparam int m63 = 16;
    localparam int m64 = 17;
    localparam int m73 = 18;
    localparam int m74 = 19;
    localparam int m56 = 20;
    localparam int m57 = 21;
    localparam int m66 = 22;
    localparam int m67 = 23;
    localparam int m08 = 24;  // column 8 is the right-hand side
    localparam int m18 = 25;
    localparam int m28 = 26;
    localparam int m38 = 27;
    localparam int m48 = 28;
    localparam int m58 = 29;
    localparam int m68 = 30;
    localparam int m78 = 31;

endpackage

`default_nettype wire

/* fix_mul_sat.sv */
`timescale 1ns/1ps
`default_nettype none

`include "persp_config.svh"

module fix_mul_sat (
    input  persp_pkg::fix_t i_a,
    input  persp_pkg::fix_t i_b,
    output persp_pkg::fix_t o_p
);
    import persp_pkg::*;

    logic signed [2*fix_w-1:0] prod;
    logic [`PERSP_INT_W:0]     prod_hi;  // slice sign bit and everything above it
    logic                      ovf;

    assign prod = i_a * i_b;

    assign prod_hi = prod[2*fix_w-1 -: `PERSP_INT_W+1];

    // fits only if the top bits are a pure sign extension
    assign ovf = !((&prod_hi) || !(|prod_hi));

    // clamp direction from the operand signs
    assign o_p = ovf ? sat_limit(i_a[fix_w-1] ^ i_b[fix_w-1])
                     : prod[fix_w+`PERSP_FRAC_W-1 -: fix_w];

endmodule

`default_nettype wire

/* fix_div_sat.sv */
`timescale 1ns/1ps
`default_nettype none

`include "persp_config.svh"

module fix_div_sat (
    input  persp_pkg::fix_t i_num,
    input  persp_pkg::fix_t i_den,
    output persp_pkg::fix_t o_q
);
    import persp_pkg::*;

    localparam int ext_w = fix_w + `PERSP_FRAC_W;

    logic signed [ext_w-1:0] num_ext;
    logic signed [ext_w-1:0] quot;
    logic [`PERSP_FRAC_W:0]  quot_hi;
    logic                    den_zero;
    logic                    ovf;

    // align the dividend so the quotient keeps the fraction
    assign num_ext = {i_num, {`PERSP_FRAC_W{1'b0}}};

    assign quot = num_ext / i_den;

    assign quot_hi  = quot[ext_w-1 -: `PERSP_FRAC_W+1];
    assign den_zero = (i_den == '0);

    // zero divisor clamps toward the numerator sign
    assign ovf = den_zero || !((&quot_hi) || !(|quot_hi));

    assign o_q = ovf ? sat_limit(i_num[fix_w-1] ^ i_den[fix_w-1])
                     : quot[fix_w-1:0];

endmodule

`default_nettype wire

/* persp_matrix_load.sv */
`timescale 1ns/1ps
`default_nettype none

`include "persp_config.svh"

module persp_matrix_load (
    input  persp_pkg::quad_t     i_quad,
    output persp_pkg::elim_mat_t o_mat
);
    import persp_pkg::*;

    typedef logic signed [`PERSP_INT_W-1:0] int_t;

    localparam int_t tgt_max = int_t'(`PERSP_TGT_MAX);

    int_t ul_x, ul_y;
    int_t dl_dx, dl_dy;
    int_t dr_dx, dr_dy;
    int_t ur_dx, ur_dy;

    // integer field only, fraction stays zero
    function automatic fix_t to_fix(input int_t v);
        return {v, {`PERSP_FRAC_W{1'b0}}};
    endfunction

    function automatic int_t ext(input coord_t c);
        return int_t'(c);
    endfunction

    // -99 * coordinate
    function automatic int_t neg_tgt(input coord_t c);
        return -(tgt_max * ext(c));
    endfunction

    assign ul_x  = ext(i_quad.ul.x);
    assign ul_y  = ext(i_quad.ul.y);
    assign dl_dx = ext(i_quad.dl.x) - ul_x;
    assign dl_dy = ext(i_quad.dl.y) - ul_y;
    assign dr_dx = ext(i_quad.dr.x) - ul_x;
    assign dr_dy = ext(i_quad.dr.y) - ul_y;
    assign ur_dx = ext(i_quad.ur.x) - ul_x;
    assign ur_dy = ext(i_quad.ur.y) - ul_y;

    always_comb begin
        // rows 0..3
        o_mat[m00] = to_fix(ul_x);
        o_mat[m01] = to_fix(ul_y);
        o_mat[m10] = to_fix(dl_dx);
        o_mat[m11] = to_fix(dl_dy);
        o_mat[m20] = to_fix(dr_dx);
        o_mat[m21] = to_fix(dr_dy);
        o_mat[m30] = to_fix(ur_dx);
        o_mat[m31] = to_fix(ur_dy);
        o_mat[m26] = to_fix(neg_tgt(i_quad.dr.x));
        o_mat[m27] = to_fix(neg_tgt(i_quad.dr.y));
        o_mat[m36] = to_fix(neg_tgt(i_quad.ur.x));
        o_mat[m37] = to_fix(neg_tgt(i_quad.ur.y));
        // rows 4..7, same differences, other projective terms
        o_mat[m43] = to_fix(ul_x);
        o_mat[m44] = to_fix(ul_y);
        o_mat[m53] = to_fix(dl_dx);
        o_mat[m54] = to_fix(dl_dy);
        o_mat[m63] = to_fix(dr_dx);
        o_mat[m64] = to_fix(dr_dy);
        o_mat[m73] = to_fix(ur_dx);
        o_mat[m74] = to_fix(ur_dy);
        o_mat[m56] = to_fix(neg_tgt(i_quad.dl.x));
        o_mat[m57] = to_fix(neg_tgt(i_quad.dl.y));
        o_mat[m66] = to_fix(neg_tgt(i_quad.dr.x));
        o_mat[m67] = to_fix(neg_tgt(i_quad.dr.y));
        // target y column
        o_mat[m08] = '0;
        o_mat[m18] = '0;
        o_mat[m28] = to_fix(tgt_max);
        o_mat[m38] = to_fix(tgt_max);
        o_mat[m48] = '0;
        o_mat[m58] = to_fix(tgt_max);
        o_mat[m68] = to_fix(tgt_max);
        o_mat[m78] = '0;
    end

endmodule

`default_nettype wire

/* persp_elim_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "persp_config.svh"

module persp_elim_core (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_start,
    input  persp_pkg::elim_mat_t i_init,
    output persp_pkg::coef_t     o_coef,
    output logic                 o_valid
);
    import persp_pkg::*;

    localparam int    n_mul     = 6;
    localparam int    n_div     = 3;
    localparam step_t last_step = step_t'(`PERSP_STEPS - 1);

    typedef enum logic {
        st_idle,
        st_calc
    } state_e;

    state_e    state_q, state_d;
    step_t     step_q, step_d;
    elim_mat_t mat_q, mat_d;
    coef_t     coef_q, coef_d;
    logic      valid_q, valid_d;

    fix_t mul_a [n_mul];
    fix_t mul_b [n_mul];
    fix_t mul_p [n_mul];
    fix_t div_n [n_div];
    fix_t div_d [n_div];
    fix_t div_q [n_div];

    for (genvar i = 0; i < n_mul; i++) begin : g_mul
        fix_mul_sat fix_mul_sat_i (
            .i_a (mul_a[i]),
            .i_b (mul_b[i]),
            .o_p (mul_p[i])
        );
    end

    for (genvar i = 0; i < n_div; i++) begin : g_div
        fix_div_sat fix_div_sat_i (
            .i_num (div_n[i]),
            .i_den (div_d[i]),
            .o_q   (div_q[i])
        );
    end

    // quotients feed the multipliers within the same cycle
    always_comb begin
        state_d = state_q;
        step_d  = step_q;
        mat_d   = mat_q;
        coef_d  = coef_q;
        valid_d = 1'b0;
        mul_a   = '{default: '0};
        mul_b   = '{default: '0};
        div_n   = '{default: '0};
        div_d   = '{default: '0};
        case (state_q)
            st_idle: begin
                if (i_start) begin
                    mat_d   = i_init;
                    step_d  = '0;
                    state_d = st_calc;
                end
            end
            st_calc: begin
                step_d = step_q + 1'b1;  // wraps to 0 after the last step
                case (step_q)
                    3'd0: begin
                        // pivot row 1 on column 1
                        div_n[0:1] = '{mat_q[m10], mat_q[m18]};
                        div_d[0:1] = '{mat_q[m11], mat_q[m11]};
                        mat_d[m10] = div_q[0];
                        mat_d[m11] = fix_one;
                        mat_d[m18] = div_q[1];
                        mul_a = '{div_q[0], div_q[1], div_q[0], div_q[1], div_q[0], div_q[1]};
                        mul_b = '{mat_q[m01], mat_q[m01], mat_q[m21],
                                  mat_q[m21], mat_q[m31], mat_q[m31]};
                        mat_d[m01] = '0;
                        mat_d[m21] = '0;
                        mat_d[m31] = '0;
                        mat_d[m00] = mat_q[m00] - mul_p[0];
                        mat_d[m08] = mat_q[m08] - mul_p[1];
                        mat_d[m20] = mat_q[m20] - mul_p[2];
                        mat_d[m28] = mat_q[m28] - mul_p[3];
                        mat_d[m30] = mat_q[m30] - mul_p[4];
                        mat_d[m38] = mat_q[m38] - mul_p[5];
                    end
                    3'd1: begin
                        // pivot row 7 on column 4
                        div_n[0:1] = '{mat_q[m73], mat_q[m78]};
                        div_d[0:1] = '{mat_q[m74], mat_q[m74]};
                        mat_d[m73] = div_q[0];
                        mat_d[m74] = fix_one;
                        mat_d[m78] = div_q[1];
                        mul_a = '{div_q[0], div_q[1], div_q[0], div_q[1], div_q[0], div_q[1]};
                        mul_b = '{mat_q[m44], mat_q[m44], mat_q[m54],
                                  mat_q[m54], mat_q[m64], mat_q[m64]};
                        mat_d[m44] = '0;
                        mat_d[m54] = '0;
                        mat_d[m64] = '0;
                        mat_d[m43] = mat_q[m43] - mul_p[0];
                        mat_d[m48] = mat_q[m48] - mul_p[1];
                        mat_d[m53] = mat_q[m53] - mul_p[2];
                        mat_d[m58] = mat_q[m58] - mul_p[3];
                        mat_d[m63] = mat_q[m63] - mul_p[4];
                        mat_d[m68] = mat_q[m68] - mul_p[5];
                    end
                    3'd2: begin
                        div_n = '{mat_q[m26], mat_q[m27], mat_q[m28]};
                        div_d = '{mat_q[m20], mat_q[m20], mat_q[m20]};
                        mat_d[m20] = fix_one;
                        mat_d[m26] = div_q[0];
                        mat_d[m27] = div_q[1];
                        mat_d[m28] = div_q[2];
                        mul_a[0:2] = div_q;
                        mul_b[0:2] = '{mat_q[m30], mat_q[m30], mat_q[m30]};
                        mat_d[m30] = '0;
                        mat_d[m36] = mat_q[m36] - mul_p[0];
                        mat_d[m37] = mat_q[m37] - mul_p[1];
                        mat_d[m38] = mat_q[m38] - mul_p[2];
                    end
                    3'd3: begin
                        div_n = '{mat_q[m56], mat_q[m57], mat_q[m58]};
                        div_d = '{mat_q[m53], mat_q[m53], mat_q[m53]};
                        mat_d[m53] = fix_one;
                        mat_d[m56] = div_q[0];
                        mat_d[m57] = div_q[1];
                        mat_d[m58] = div_q[2];
                        mul_a[0:2] = div_q;
                        mul_b[0:2] = '{mat_q[m63], mat_q[m63], mat_q[m63]};
                        mat_d[m63] = '0;
                        mat_d[m66] = mat_q[m66] - mul_p[0];
                        mat_d[m67] = mat_q[m67] - mul_p[1];
                        mat_d[m68] = mat_q[m68] - mul_p[2];
                    end
                    3'd4: begin
                        // row 6 pivot, then clear column 6 in rows 2, 3, 5
                        div_n[0:1] = '{mat_q[m67], mat_q[m68]};
                        div_d[0:1] = '{mat_q[m66], mat_q[m66]};
                        mat_d[m66] = fix_one;
                        mat_d[m67] = div_q[0];
                        mat_d[m68] = div_q[1];
                        mul_a = '{mat_q[m26], mat_q[m26], mat_q[m36],
                                  mat_q[m36], mat_q[m56], mat_q[m56]};
                        mul_b = '{div_q[0], div_q[1], div_q[0], div_q[1], div_q[0], div_q[1]};
                        mat_d[m26] = '0;
                        mat_d[m36] = '0;
                        mat_d[m56] = '0;
                        mat_d[m27] = mat_q[m27] - mul_p[0];
                        mat_d[m28] = mat_q[m28] - mul_p[1];
                        mat_d[m37] = mat_q[m37] - mul_p[2];
                        mat_d[m38] = mat_q[m38] - mul_p[3];
                        mat_d[m57] = mat_q[m57] - mul_p[4];
                        mat_d[m58] = mat_q[m58] - mul_p[5];
                    end
                    3'd5: begin
                        div_n[0] = mat_q[m38];
                        div_d[0] = mat_q[m37];
                        mat_d[m37] = fix_one;
                        mat_d[m38] = div_q[0];  // h
                        mul_a[0:2] = '{div_q[0], div_q[0], div_q[0]};
                        mul_b[0:2] = '{mat_q[m27], mat_q[m57], mat_q[m67]};
                        mat_d[m27] = '0;
                        mat_d[m57] = '0;
                        mat_d[m67] = '0;
                        mat_d[m28] = mat_q[m28] - mul_p[0];
                        mat_d[m58] = mat_q[m58] - mul_p[1];
                        mat_d[m68] = mat_q[m68] - mul_p[2];
                    end
                    3'd6: begin
                        // back-substitute into c, b, f, e
                        mul_a[0:3] = '{mat_q[m00], mat_q[m10], mat_q[m43], mat_q[m73]};
                        mul_b[0:3] = '{mat_q[m28], mat_q[m28], mat_q[m58], mat_q[m58]};
                        mat_d[m08] = mat_q[m08] - mul_p[0];
                        mat_d[m18] = mat_q[m18] - mul_p[1];
                        mat_d[m48] = mat_q[m48] - mul_p[2];
                        mat_d[m78] = mat_q[m78] - mul_p[3];
                    end
                    last_step: begin
                        coef_d.a = mat_q[m28];
                        coef_d.b = mat_q[m18];
                        coef_d.c = mat_q[m08];
                        coef_d.d = mat_q[m58];
                        coef_d.e = mat_q[m78];
                        coef_d.f = mat_q[m48];
                        coef_d.g = mat_q[m68];
                        coef_d.h = mat_q[m38];
                        valid_d  = 1'b1;
                        state_d  = st_idle;  // ready for a start in the valid cycle
                    end
                endcase
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= st_idle;
            step_q  <= '0;
            coef_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            step_q  <= step_d;
            coef_q  <= coef_d;
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge i_clk) begin
        mat_q <= mat_d;
    end

    assign o_coef  = coef_q;
    assign o_valid = valid_q;

endmodule

`default_nettype wire

/* persp_solver_top.sv */
`timescale 1ns/1ps
`default_nettype none

module persp_solver_top (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_start,
    input  persp_pkg::quad_t i_quad,
    output persp_pkg::coef_t o_coef,
    output logic             o_valid
);
    import persp_pkg::*;

    elim_mat_t init_mat;  // follows i_quad, sampled by the core on start

    persp_matrix_load persp_matrix_load_i (
        .i_quad (i_quad),
        .o_mat  (init_mat)
    );

    persp_elim_core persp_elim_core_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .i_init  (init_mat),
        .o_coef  (o_coef),
        .o_valid (o_valid)
    );

endmodule

`default_nettype wire

/* persp_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module persp_properties (
    input logic             i_clk,
    input logic             i_rst_n,
    input logic             i_start,
    input logic             i_busy,
    input logic             o_valid,
    input persp_pkg::coef_t o_coef
);
    logic accepted;
    int   fail_count = 0;  // failed assertion count

    assign accepted = i_start && !i_busy;  // core idle

    // result lands eight edges after the accepting edge, sampled high one edge later
    a_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        accepted |-> ##1 (!o_valid) [*8] ##1 o_valid)
        else begin
            fail_count++;
            $error("valid did not follow the accepted start by eight cycles");
        end

    a_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid |=> !o_valid)
        else begin
            fail_count++;
            $error("valid held for more than one cycle");
        end

    a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !o_valid |-> $stable(o_coef))
        else begin
            fail_count++;
            $error("coefficients changed without a valid pulse");
        end

endmodule

bind persp_elim_core persp_properties persp_properties_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_start (i_start),
    .i_busy  (state_q),
    .o_valid (o_valid),
    .o_coef  (o_coef)
);

`default_nettype wire

/* tb_persp_solver.sv */
`timescale 1ns/1ps
`default_nettype none

`include "persp_config.svh"

module tb_persp_solver;
    import persp_pkg::*;

    localparam int words_per_case = 16;
    localparam int max_cases      = 16;
    localparam int max_wait       = 20;

    logic  i_clk;
    logic  i_rst_n;
    logic  i_start;
    quad_t i_quad;
    coef_t o_coef;
    logic  o_valid;

    logic [fix_w-1:0] golden_mem [words_per_case*max_cases];
    int               n_cases = 0;

    persp_solver_top persp_solver_top_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .i_quad  (i_quad),
        .o_coef  (o_coef),
        .o_valid (o_valid)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_fix(input fix_t got, input fix_t exp, input string name);
        if (got !== exp)
            stop_on_error($sformatf("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp));
    endtask

    task automatic check_coef(input coef_t got, input coef_t exp);
        check_fix(got.a, exp.a, "o_coef.a");
        check_fix(got.b, exp.b, "o_coef.b");
        check_fix(got.c, exp.c, "o_coef.c");
        check_fix(got.d, exp.d, "o_coef.d");
        check_fix(got.e, exp.e, "o_coef.e");
        check_fix(got.f, exp.f, "o_coef.f");
        check_fix(got.g, exp.g, "o_coef.g");
        check_fix(got.h, exp.h, "o_coef.h");
    endtask

    task automatic check_valid_cycle(input int got, input int exp);
        if (got != exp)
            stop_on_error($sformatf("ERR t=%0t o_valid_latency got=%0d exp=%0d",
                                    $time, got, exp));
    endtask

    task automatic check_valid_level(input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("ERR t=%0t o_valid got=%b exp=%b", $time, got, exp));
    endtask

    function automatic quad_t golden_quad(input int idx);
        int b;
        b = idx * words_per_case;
        return '{ul: '{golden_mem[b][9:0],   golden_mem[b+1][9:0]},
                 ur: '{golden_mem[b+2][9:0], golden_mem[b+3][9:0]},
                 dr: '{golden_mem[b+4][9:0], golden_mem[b+5][9:0]},
                 dl: '{golden_mem[b+6][9:0], golden_mem[b+7][9:0]}};
    endfunction

    function automatic coef_t golden_coef(input int idx);
        int b;
        b = idx * words_per_case + 8;
        return '{golden_mem[b],   golden_mem[b+1], golden_mem[b+2], golden_mem[b+3],
                 golden_mem[b+4], golden_mem[b+5], golden_mem[b+6], golden_mem[b+7]};
    endfunction

    // called at a falling edge, returns one falling edge after the accepting edge
    task automatic drive_start(input int idx);
        i_quad  = golden_quad(idx);
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
    endtask

    // counts edges after the accepting edge while o_coef holds
    task automatic wait_valid(input int first, input coef_t hold, output int cycles);
        cycles = first;
        while (o_valid !== 1'b1) begin
            check_coef(o_coef, hold);
            if (cycles >= max_wait)
                stop_on_error("no valid pulse appeared within 20 cycles of a start");
            @(negedge i_clk);
            cycles++;
        end
    endtask

    // bound core assertions
    always @(persp_solver_top_i.persp_elim_core_i.persp_properties_i.fail_count) begin
        if (persp_solver_top_i.persp_elim_core_i.persp_properties_i.fail_count != 0)
            stop_on_error("an assertion on the elimination core failed");
    end

    initial begin
        wait (i_rst_n === 1'b1);
        repeat (n_cases * 20 + 100) @(posedge i_clk);
        $display("watchdog expired before the tests completed");
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        coef_t prev;
        int    cycles;

        i_rst_n  = 1'b0;
        i_start  = 1'b0;
        i_quad   = '0;
        void'($urandom(32'hc157));

        foreach (golden_mem[i]) golden_mem[i] = '1;  // sentinel, never a coordinate
        $readmemh("persp_golden.txt", golden_mem);
        while (n_cases < max_cases && golden_mem[n_cases*words_per_case] !== '1)
            n_cases++;
        if (n_cases < 2)
            stop_on_error("golden file holds fewer than two test cases");

        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        // quiet after reset
        repeat (5) begin
            check_valid_level(o_valid, 1'b0);
            check_coef(o_coef, '0);
            @(negedge i_clk);
        end

        prev = '0;
        for (int k = 0; k < n_cases; k++) begin
            drive_start(k);
            wait_valid(0, prev, cycles);
            check_valid_cycle(cycles, `PERSP_STEPS);
            check_coef(o_coef, golden_coef(k));
            prev = golden_coef(k);
            @(negedge i_clk);
            check_valid_level(o_valid, 1'b0);
            repeat ($urandom % 4) @(negedge i_clk);
        end

        // starts while busy must be dropped
        drive_start(0);
        i_quad  = golden_quad(1);
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        @(negedge i_clk);
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        wait_valid(3, prev, cycles);
        check_valid_cycle(cycles, `PERSP_STEPS);
        check_coef(o_coef, golden_coef(0));
        prev = golden_coef(0);
        repeat (12) begin
            @(negedge i_clk);
            check_valid_level(o_valid, 1'b0);
            check_coef(o_coef, prev);
        end

        // back to back, each start sits in the previous valid cycle
        drive_start(0);
        wait_valid(0, prev, cycles);
        check_valid_cycle(cycles, `PERSP_STEPS);
        check_coef(o_coef, golden_coef(0));
        for (int k = 1; k < n_cases; k++) begin
            prev = golden_coef(k - 1);
            drive_start(k);
            wait_valid(0, prev, cycles);
            check_valid_cycle(cycles, `PERSP_STEPS);
            check_coef(o_coef, golden_coef(k));
        end
        @(negedge i_clk);
        check_valid_level(o_valid, 1'b0);
        repeat (3) @(negedge i_clk);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* persp_golden.txt */
// cols 1-8: corners as hex coordinates, ul_x ul_y ur_x ur_y dr_x dr_y dl_x dl_y
// cols 9-16: expected coefficients a b c d e f g h, 33-bit two's complement Q20.13 hex
// values follow the saturating multiply and divide and the wrapping subtract
//
// every corner at the origin, all pivots divide by zero
000 000 000 000 000 000 000 000
000000000 0FFFFFFFF 000000000 000000000 0FFFFFFFF 000000000 000000000 0FFFFFFFF
//
// corners equal to the target square
000 000 000 063 063 063 063 000
1FFFFD41A 1FFFFFFFF 000000000 000102001 000000000 000000000 0000FFFFF 1FFFFE002
//
// every corner at 1023
3FF 3FF 3FF 3FF 3FF 3FF 3FF 3FF
0FFBFFFFF 000000000 000000001 0FFBFFFFF 000000000 000000001 0FFFFFFF9 0FFFFFFFF
//
// full 0..1023 square, large products saturate
000 000 000 3FF 3FF 3FF 3FF 000
19CEE8D9E 1FFFFFFFF 000000000 000000318 000000000 000000000 1FFFFFFFF 000002001

/* all.f */
+incdir+.
persp_pkg.sv
fix_mul_sat.sv
fix_div_sat.sv
persp_matrix_load.sv
persp_elim_core.sv
persp_solver_top.sv
persp_properties.sv
tb_persp_solver.sv
